// File: fm_sample_pkg.sv
package fm_sample_pkg;

    // signed Q21.10 audio word
    localparam int SAMPLE_W  = 32;
    localparam int FRAC_BITS = 10;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // plain full/empty strobes of one FIFO
    typedef struct packed {
        logic full;
        logic empty;
    } fifo_status_t;

    // fixed-point product, rescaled back to Q10 and wrapped to one word
    function automatic sample_t mul_frac(input sample_t a, input sample_t b);
        logic signed [2*SAMPLE_W-1:0] prod;
        prod = a * b;
        return sample_t'(prod >>> FRAC_BITS);
    endfunction

endpackage

// File: fm_filter_pkg.sv
package fm_filter_pkg;

    localparam int TAPS_DEFAULT  = 16;
    localparam int DECIM_DEFAULT = 8;

    // symmetric low-pass, Q10, sum close to unity gain
    localparam fm_sample_pkg::sample_t LPR_COEFFS [0:TAPS_DEFAULT-1] = '{
        -32'sd3,
        -32'sd6,
        32'sd0,
        32'sd20,
        32'sd57,
        32'sd106,
        32'sd152,
        32'sd180,
        32'sd180,
        32'sd152,
        32'sd106,
        32'sd57,
        32'sd20,
        32'sd0,
        -32'sd6,
        -32'sd3
    };

    // per-cycle datapath strobes from the controller
    typedef struct packed {
        logic sample_shift;
        logic acc_clear;
        logic acc_step;
    } fir_cmd_t;

endpackage

// File: sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  fm_sample_pkg::sample_t      din,
    input  logic                        rd_en,
    output fm_sample_pkg::sample_t      dout,
    output fm_sample_pkg::fifo_status_t status
);
    import fm_sample_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    sample_t          mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // strobes are dropped when they cannot be served
    assign do_wr = wr_en && !status.full;
    assign do_rd = rd_en && !status.empty;

    assign status.full  = (count == FULL_CNT);
    assign status.empty = (count == '0);

    // first word falls through
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: fir_ctrl_fsm.sv
`timescale 1ns/10ps

module fir_ctrl_fsm (
    input  logic                        clock,
    input  logic                        rst_n,
    input  fm_sample_pkg::fifo_status_t in_status,
    input  fm_sample_pkg::fifo_status_t out_status,
    input  logic                        dec_last,
    input  logic                        tap_last,
    output fm_filter_pkg::fir_cmd_t     cmd,
    output logic                        in_rd_en,
    output logic                        out_wr_en
);

    typedef enum logic [1:0] {
        READ,
        CLEAR,
        MAC,
        WRITE
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= READ;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        cmd        = '0;
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;
        next_state = state;
        case (state)
            READ: begin
                // pop and shift in the same cycle
                if (!in_status.empty) begin
                    in_rd_en         = 1'b1;
                    cmd.sample_shift = 1'b1;
                    if (dec_last) begin
                        next_state = CLEAR;
                    end
                end
            end
            CLEAR: begin
                cmd.acc_clear = 1'b1;
                next_state    = MAC;
            end
            MAC: begin
                // one tap per cycle
                cmd.acc_step = 1'b1;
                if (tap_last) begin
                    next_state = WRITE;
                end
            end
            WRITE: begin
                // hold the result until the output FIFO has room
                if (!out_status.full) begin
                    out_wr_en  = 1'b1;
                    next_state = READ;
                end
            end
            default: begin
                next_state = READ;
            end
        endcase
    end

endmodule

// File: tap_counter.sv
`timescale 1ns/10ps

module tap_counter #(
    parameter int TAPS       = 16,
    parameter int DECIMATION = 8
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  fm_filter_pkg::fir_cmd_t     cmd,
    output logic [$clog2(TAPS)-1:0]     tap_idx,
    output logic                        dec_last,
    output logic                        tap_last
);

    localparam int IDX_W = $clog2(TAPS);
    localparam int DEC_W = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;

    logic [DEC_W-1:0] dec_cnt;

    assign dec_last = (dec_cnt == DEC_W'(DECIMATION - 1));
    assign tap_last = (tap_idx == IDX_W'(TAPS - 1));

    // samples read since the last output
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dec_cnt <= '0;
        end else if (cmd.sample_shift) begin
            dec_cnt <= dec_last ? '0 : dec_cnt + 1'b1;
        end
    end

    // tap position within one MAC pass
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            tap_idx <= '0;
        end else if (cmd.acc_clear) begin
            tap_idx <= '0;
        end else if (cmd.acc_step) begin
            tap_idx <= tap_last ? '0 : tap_idx + 1'b1;
        end
    end

endmodule

// File: fir_mac.sv
`timescale 1ns/10ps

module fir_mac #(
    parameter int TAPS = 16
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  fm_filter_pkg::fir_cmd_t     cmd,
    input  fm_sample_pkg::sample_t      sample,
    input  logic [$clog2(TAPS)-1:0]     tap_idx,
    output fm_sample_pkg::sample_t      acc
);
    import fm_sample_pkg::*;
    import fm_filter_pkg::*;

    sample_t delay_line [TAPS];
    sample_t tap_prod;

    // x[n-k] * h[k] for the current tap
    assign tap_prod = mul_frac(delay_line[tap_idx], LPR_COEFFS[tap_idx]);

    // newest sample at position 0, oldest drops off the end
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < TAPS; i++) begin
                delay_line[i] <= '0;
            end
        end else if (cmd.sample_shift) begin
            delay_line[0] <= sample;
            for (int i = 1; i < TAPS; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    // wraps at 32 bits like the fixed-point reference
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (cmd.acc_clear) begin
            acc <= '0;
        end else if (cmd.acc_step) begin
            acc <= acc + tap_prod;
        end
    end

endmodule

// File: fm_audio_lpr_top.sv
`timescale 1ns/10ps

module fm_audio_lpr_top #(
    parameter int TAPS       = fm_filter_pkg::TAPS_DEFAULT,
    parameter int DECIMATION = fm_filter_pkg::DECIM_DEFAULT,
    parameter int IN_DEPTH   = 16,
    parameter int OUT_DEPTH  = 8
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  fm_sample_pkg::sample_t din,
    input  logic                   in_wr_en,
    output logic                   in_full,
    input  logic                   out_rd_en,
    output logic                   out_empty,
    output fm_sample_pkg::sample_t dout
);
    import fm_sample_pkg::*;
    import fm_filter_pkg::*;

    localparam int IDX_W = $clog2(TAPS);

    fifo_status_t     in_status;
    fifo_status_t     out_status;
    sample_t          in_head;
    sample_t          acc;
    fir_cmd_t         cmd;
    logic             in_rd_en;
    logic             out_wr_en;
    logic             dec_last;
    logic             tap_last;
    logic [IDX_W-1:0] tap_idx;

    assign in_full   = in_status.full;
    assign out_empty = out_status.empty;

    // baseband samples waiting for the filter
    sample_fifo #(
        .DEPTH(IN_DEPTH)
    ) in_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .wr_en (in_wr_en),
        .din   (din),
        .rd_en (in_rd_en),
        .dout  (in_head),
        .status(in_status)
    );

    fir_ctrl_fsm ctrl (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_status (in_status),
        .out_status(out_status),
        .dec_last  (dec_last),
        .tap_last  (tap_last),
        .cmd       (cmd),
        .in_rd_en  (in_rd_en),
        .out_wr_en (out_wr_en)
    );

    tap_counter #(
        .TAPS      (TAPS),
        .DECIMATION(DECIMATION)
    ) counter (
        .clock   (clock),
        .rst_n   (rst_n),
        .cmd     (cmd),
        .tap_idx (tap_idx),
        .dec_last(dec_last),
        .tap_last(tap_last)
    );

    fir_mac #(
        .TAPS(TAPS)
    ) mac (
        .clock  (clock),
        .rst_n  (rst_n),
        .cmd    (cmd),
        .sample (in_head),
        .tap_idx(tap_idx),
        .acc    (acc)
    );

    // decimated audio for the outside reader
    sample_fifo #(
        .DEPTH(OUT_DEPTH)
    ) out_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .wr_en (out_wr_en),
        .din   (acc),
        .rd_en (out_rd_en),
        .dout  (dout),
        .status(out_status)
    );

endmodule

// File: fm_audio_lpr_assertions.sv
`timescale 1ns/10ps

module fm_audio_lpr_assertions (
    input logic                        clock,
    input logic                        rst_n,
    input fm_sample_pkg::fifo_status_t in_status,
    input fm_sample_pkg::fifo_status_t out_status,
    input fm_filter_pkg::fir_cmd_t     cmd,
    input logic                        in_rd_en,
    input logic                        out_wr_en
);

    // no write into a full output FIFO
    out_wr_room: assert property (@(posedge clock) disable iff (!rst_n)
        out_wr_en |-> !out_status.full)
        else $error("out_wr_en high while the output FIFO is full");

    // no pop from an empty input FIFO
    in_rd_data: assert property (@(posedge clock) disable iff (!rst_n)
        in_rd_en |-> !in_status.empty)
        else $error("in_rd_en high while the input FIFO is empty");

    // shift and MAC belong to different phases
    shift_vs_step: assert property (@(posedge clock) disable iff (!rst_n)
        !(cmd.sample_shift && cmd.acc_step))
        else $error("sample_shift and acc_step high in the same cycle");

endmodule

bind fir_ctrl_fsm fm_audio_lpr_assertions ctrl_checks (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_status (in_status),
    .out_status(out_status),
    .cmd       (cmd),
    .in_rd_en  (in_rd_en),
    .out_wr_en (out_wr_en)
);

// File: tb_fm_audio_lpr.sv
`timescale 1ns/10ps

module tb_fm_audio_lpr;
    import fm_sample_pkg::*;
    import fm_filter_pkg::*;

    localparam int TAPS        = TAPS_DEFAULT;
    localparam int DECIMATION  = DECIM_DEFAULT;
    localparam int IN_DEPTH    = 16;
    localparam int OUT_DEPTH   = 8;
    // impulse, random stream, back-pressure, writes while full, tail stream
    localparam int NUM_SAMPLES = 128 + 400 + 400 + 420 + 64;
    localparam int RUN_LIMIT_NS = NUM_SAMPLES * (TAPS + DECIMATION + 4) * 4 * 2;
    // a stall parks a full output FIFO, one result in the MAC and a full input FIFO
    localparam int STALL_WORDS = OUT_DEPTH + 1 + IN_DEPTH / DECIMATION;
    localparam int NUM_WORDS   = (128 + 400 + 64) / DECIMATION + 2 * STALL_WORDS;
    localparam fifo_status_t IDLE_FLAGS    = '{full: 1'b0, empty: 1'b1};
    localparam fifo_status_t STALLED_FLAGS = '{full: 1'b1, empty: 1'b0};

    logic    clock;
    logic    rst_n;
    sample_t din;
    logic    in_wr_en;
    logic    in_full;
    logic    out_rd_en;
    logic    out_empty;
    sample_t dout;

    int      seed;
    int      ref_count;
    int      n_checked;
    sample_t ref_delay [TAPS];
    sample_t exp_q [$];

    fm_audio_lpr_top #(
        .IN_DEPTH (IN_DEPTH),
        .OUT_DEPTH(OUT_DEPTH)
    ) dut (
        .clock    (clock),
        .rst_n    (rst_n),
        .din      (din),
        .in_wr_en (in_wr_en),
        .in_full  (in_full),
        .out_rd_en(out_rd_en),
        .out_empty(out_empty),
        .dout     (dout)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    // bounded random sample, roughly +/- 2^20
    function automatic sample_t rand_sample();
        return sample_t'($random(seed) % 1048576);
    endfunction

    // one decimated output from the reference delay line
    function automatic sample_t fir_reference();
        sample_t sum;
        sum = '0;
        for (int k = 0; k < TAPS; k++) begin
            sum = sum + mul_frac(ref_delay[k], LPR_COEFFS[k]);
        end
        return sum;
    endfunction

    task automatic accept_input(input sample_t x);
        for (int i = TAPS - 1; i > 0; i--) begin
            ref_delay[i] = ref_delay[i-1];
        end
        ref_delay[0] = x;
        if (ref_count == DECIMATION - 1) begin
            ref_count = 0;
            exp_q.push_back(fir_reference());
        end else begin
            ref_count++;
        end
    endtask

    task automatic check_sample(input sample_t expected, input sample_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: audio word expected %0d, got %0d",
                     $time, expected, actual);
            abort_run("filter output differs from the reference");
        end else begin
            n_checked++;
        end
    endtask

    task automatic check_flags(input fifo_status_t expected, input fifo_status_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: in_full,out_empty expected %b, got %b",
                     $time, expected, actual);
            abort_run("FIFO flags are wrong");
        end
    endtask

    function automatic fifo_status_t flags_now();
        return '{full: in_full, empty: out_empty};
    endfunction

    // holds the word until the input FIFO takes it
    task automatic send_sample(input sample_t x);
        in_wr_en <= 1'b1;
        din      <= x;
        @(posedge clock);
        while (in_full) begin
            @(posedge clock);
        end
    endtask

    // one write attempt, taken or not
    task automatic try_write(input sample_t x);
        in_wr_en <= 1'b1;
        din      <= x;
        @(posedge clock);
    endtask

    task automatic drain_outputs();
        in_wr_en  <= 1'b0;
        out_rd_en <= 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
    endtask

    task automatic stall_and_fill(input int n_cycles);
        out_rd_en <= 1'b0;
        repeat (n_cycles) try_write(rand_sample());
        in_wr_en <= 1'b0;
        @(posedge clock);
        check_flags(STALLED_FLAGS, flags_now());
    endtask

    // input writes the DUT really took
    always @(posedge clock) begin
        if (rst_n && in_wr_en && !in_full) begin
            accept_input(din);
        end
    end

    // output words popped at this edge
    always @(posedge clock) begin
        if (rst_n && out_rd_en && !out_empty) begin
            if (exp_q.size() == 0) begin
                abort_run("output word arrived with no expected value");
            end else begin
                check_sample(exp_q.pop_front(), dout);
            end
        end
    end

    initial begin
        #(RUN_LIMIT_NS);
        abort_run("timeout, the expected output did not arrive in time");
    end

    initial begin
        seed       = 97433;
        rst_n      = 1'b0;
        din        = '0;
        in_wr_en   = 1'b0;
        out_rd_en  = 1'b0;
        ref_count  = 0;
        n_checked  = 0;
        for (int i = 0; i < TAPS; i++) begin
            ref_delay[i] = '0;
        end
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);
        check_flags(IDLE_FLAGS, flags_now());
        out_rd_en <= 1'b1;

        // unit impulse, then zeros
        send_sample(32'sd1024);
        repeat (127) send_sample('0);
        drain_outputs();

        repeat (400) send_sample(rand_sample());
        drain_outputs();

        // output back-pressure
        stall_and_fill(400);
        drain_outputs();

        // writes against a full input FIFO
        stall_and_fill(400);
        repeat (20) try_write(rand_sample());
        in_wr_en <= 1'b0;
        @(posedge clock);
        check_flags(STALLED_FLAGS, flags_now());
        drain_outputs();
        repeat (64) send_sample(rand_sample());
        drain_outputs();

        repeat (60) @(posedge clock);
        check_flags(IDLE_FLAGS, flags_now());
        if (n_checked == NUM_WORDS) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("number of output words differs from the expected count");
        end
    end

endmodule

// File: compile.f
fm_sample_pkg.sv
fm_filter_pkg.sv
sample_fifo.sv
fir_ctrl_fsm.sv
tap_counter.sv
fir_mac.sv
fm_audio_lpr_top.sv
fm_audio_lpr_assertions.sv
tb_fm_audio_lpr.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fm_audio_lpr \
    -f compile.f -o Vtb_fm_audio_lpr > build.log 2>&1 &&
    ./obj_dir/Vtb_fm_audio_lpr > sim.log 2>&1 ||
    echo "build or run stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "Simulation finished: FAIL" sim.log 2>/dev/null && exit 1
grep -q "Simulation finished: PASS" sim.log 2>/dev/null || exit 1
exit 0
